// ==== kcpu_pkg.sv ====
//////////////////////////////////////////////////
// KCPU execute block shared definitions
// Opcode codes, condition-code bit positions and
// the opcode class helpers
//////////////////////////////////////////////////
package kcpu_pkg;

    typedef enum logic [7:0] {
        op_ld8   = 8'h00,  // Load, test
        op_ld16  = 8'h01,
        op_tst8  = 8'h02,
        op_tst16 = 8'h03,
        op_add8  = 8'h10,  // Two-operand arithmetic
        op_add16 = 8'h11,
        op_adc   = 8'h12,
        op_sub8  = 8'h13,
        op_sub16 = 8'h14,
        op_cmp8  = 8'h15,
        op_sbc   = 8'h16,
        op_and   = 8'h20,  // Logic
        op_or    = 8'h21,
        op_eor   = 8'h22,
        op_clr   = 8'h30,  // Single operand
        op_com   = 8'h31,
        op_neg   = 8'h32,
        op_inc   = 8'h33,
        op_dec   = 8'h34,
        op_lsr   = 8'h40,  // Single-bit shifts and rotates
        op_asr   = 8'h41,
        op_asl   = 8'h42,
        op_rol   = 8'h43,
        op_ror   = 8'h44,
        op_lsrd  = 8'h48,  // Multi-bit shifts on D
        op_asld  = 8'h49,
        op_andcc = 8'h50,  // Flags and wide ops
        op_orcc  = 8'h51,
        op_sex   = 8'h52,
        op_mul   = 8'h53,
        op_lmul  = 8'h54,
        op_divxb = 8'h55
    } kcpu_op_t;

    localparam int cc_c = 0;  // Carry
    localparam int cc_v = 1;  // Overflow
    localparam int cc_z = 2;  // Zero
    localparam int cc_n = 3;  // Negative
    localparam int cc_i = 4;  // IRQ mask
    localparam int cc_h = 5;  // Half carry
    localparam int cc_f = 6;  // FIRQ mask
    localparam int cc_e = 7;  // Entire state

    // N and Z are taken at 16 bits for these
    function automatic logic is_wide(kcpu_op_t op);
        case (op)
            op_ld16, op_tst16, op_add16, op_sub16,
            op_lsrd, op_asld, op_sex, op_mul,
            op_lmul, op_divxb: is_wide = 1'b1;
            default:           is_wide = 1'b0;
        endcase
    endfunction

    // Operations that run on the divider or the shifter
    function automatic logic op_is_multi(kcpu_op_t op);
        case (op)
            op_lsrd, op_asld, op_divxb: op_is_multi = 1'b1;
            default:                    op_is_multi = 1'b0;
        endcase
    endfunction

endpackage

// ==== kcpu_div.sv ====
//////////////////////////////////////////////////
// KCPU serial divider
// Restoring 16 by 8 division, one quotient bit
// per cycle over 16 cycles
//////////////////////////////////////////////////
`timescale 1ns/1ps

module kcpu_div (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  logic        start,
    input  logic [15:0] dividend,
    input  logic [7:0]  divisor,
    output logic [15:0] quot,
    output logic [7:0]  rem,
    output logic        busy,
    output logic        v
);
    logic [4:0] cnt;
    logic [7:0] dvs;
    logic [8:0] trial;
    logic [8:0] diff;
    logic       fits;

    assign busy  = cnt != 5'd0;
    assign trial = {rem, quot[15]};             // Partial remainder shifted left
    assign diff  = trial - {1'b0, dvs};
    assign fits  = trial >= {1'b0, dvs};        // Always true for a zero divisor

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= 5'd0;
            v   <= 1'b0;
        end else if (cen) begin
            if (start) begin
                cnt <= 5'd16;
                v   <= divisor == 8'd0;
            end else if (busy) begin
                cnt <= cnt - 5'd1;
            end
        end
    end

    // Quotient bits enter from the right as the dividend leaves
    always_ff @(posedge clk) begin
        if (cen) begin
            if (start) begin
                quot <= dividend;
                rem  <= 8'd0;
                dvs  <= divisor;
            end else if (busy) begin
                quot <= {quot[14:0], fits};
                rem  <= fits ? diff[7:0] : trial[7:0];
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        cen && start |-> !busy)
        else $error("div: start while a division is running");

endmodule

// ==== kcpu_issue.sv ====
//////////////////////////////////////////////////
// KCPU issue stage
// Latches a request, launches the multi-cycle
// units and sequences the write-back strobes
//////////////////////////////////////////////////
`timescale 1ns/1ps

module kcpu_issue (
    input  logic               clk,
    input  logic               rst,
    input  logic               cen,
    input  logic               start,
    input  kcpu_pkg::kcpu_op_t op_in,
    input  logic [15:0]        a,
    input  logic [15:0]        b,
    input  logic               busy,
    output logic               ready,
    output kcpu_pkg::kcpu_op_t op,
    output logic [15:0]        opnd0,
    output logic [15:0]        opnd1,
    output logic               div_en,
    output logic               shd_en,
    output logic               cc_we,
    output logic               wb
);
    import kcpu_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_launch,
        st_wait
    } state_t;

    state_t state;
    logic   accept;

    assign ready  = state == st_idle;
    assign accept = start && ready;
    assign div_en = state == st_launch && op == op_divxb;
    assign shd_en = state == st_launch && op_is_multi(op) && op != op_divxb;
    assign cc_we  = state == st_wait;            // Shifts step C every cycle
    assign wb     = state == st_wait && !busy;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
        end else if (cen) begin
            case (state)
                st_idle:   state <= accept ? st_launch : st_idle;
                st_launch: state <= st_wait;
                st_wait:   state <= busy ? st_wait : st_idle;
                default:   state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cen && accept) begin
            op    <= op_in;
            opnd0 <= a;
            opnd1 <= b;
        end
    end

    // A single-cycle operation never keeps the unit busy
    assert property (@(posedge clk) disable iff (rst)
        cen && state == st_launch && !op_is_multi(op) |=> !busy)
        else $error("issue: busy after a single-cycle launch");

endmodule

// ==== kcpu_alu.sv ====
//////////////////////////////////////////////////
// KCPU operation unit
// Results and condition codes per opcode, the
// multi-bit shifter and the serial divider
//////////////////////////////////////////////////
`timescale 1ns/1ps

module kcpu_alu (
    input  logic               clk,
    input  logic               rst,
    input  logic               cen,
    input  kcpu_pkg::kcpu_op_t op,
    input  logic [15:0]        opnd0,
    input  logic [15:0]        opnd1,
    input  logic [7:0]         cc_in,
    input  logic               div_en,
    input  logic               shd_en,
    output logic [7:0]         cc_out,
    output logic               busy,
    output logic [15:0]        rslt,
    output logic [15:0]        rslt_hi
);
    import kcpu_pkg::*;

    logic        wide;
    logic        div_busy;
    logic        div_v;
    logic [7:0]  div_rem;
    logic [15:0] div_quot;
    logic        shd_busy;
    logic [7:0]  shd_cnt;
    logic [15:0] shd_data;
    logic [8:0]  s8;
    logic [16:0] s16;
    logic [31:0] prod;

    assign wide     = is_wide(op);
    assign shd_busy = shd_cnt != 8'd0;
    assign busy     = div_busy | shd_busy;

    kcpu_div u_div (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .start    (div_en),
        .dividend (opnd0),
        .divisor  (opnd1[7:0]),
        .quot     (div_quot),
        .rem      (div_rem),
        .busy     (div_busy),
        .v        (div_v)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            shd_cnt <= 8'd0;
        end else if (cen) begin
            if (shd_en) begin
                shd_cnt <= opnd1[7:0];           // Zero count never raises busy
            end else if (shd_busy) begin
                shd_cnt <= shd_cnt - 8'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cen) begin
            if (shd_en) begin
                shd_data <= opnd0;
            end else if (shd_busy) begin
                shd_data <= rslt;                // One bit per cycle
            end
        end
    end

    // 8-bit operations write the low byte and pass opnd0[15:8] through
    always_comb begin
        cc_out  = cc_in;
        rslt    = opnd0;
        rslt_hi = 16'd0;
        s8      = 9'd0;
        s16     = 17'd0;
        prod    = 32'd0;
        case (op)
            op_ld8: begin
                rslt[7:0]    = opnd1[7:0];
                cc_out[cc_v] = 1'b0;
            end
            op_ld16: begin
                rslt         = opnd1;
                cc_out[cc_v] = 1'b0;
            end
            op_tst8, op_tst16: cc_out[cc_v] = 1'b0;
            op_add8, op_adc: begin
                s8 = {1'b0, opnd0[7:0]} + {1'b0, opnd1[7:0]}
                   + {8'd0, op == op_adc && cc_in[cc_c]};
                rslt[7:0]    = s8[7:0];
                cc_out[cc_c] = s8[8];
                cc_out[cc_v] = opnd0[7] ^ opnd1[7] ^ s8[8] ^ s8[7];
                cc_out[cc_h] = opnd0[4] ^ opnd1[4] ^ s8[4];
            end
            op_sub8, op_cmp8, op_sbc: begin      // C is the borrow
                s8 = {1'b0, opnd0[7:0]} - {1'b0, opnd1[7:0]}
                   - {8'd0, op == op_sbc && cc_in[cc_c]};
                rslt[7:0]    = s8[7:0];
                cc_out[cc_c] = s8[8];
                cc_out[cc_v] = opnd0[7] ^ opnd1[7] ^ s8[8] ^ s8[7];
            end
            op_add16, op_sub16: begin
                s16 = op == op_add16 ? {1'b0, opnd0} + {1'b0, opnd1}
                                     : {1'b0, opnd0} - {1'b0, opnd1};
                rslt         = s16[15:0];
                cc_out[cc_c] = s16[16];
                cc_out[cc_v] = opnd0[15] ^ opnd1[15] ^ s16[16] ^ s16[15];
            end
            op_and: begin
                rslt[7:0]    = opnd0[7:0] & opnd1[7:0];
                cc_out[cc_v] = 1'b0;
            end
            op_or: begin
                rslt[7:0]    = opnd0[7:0] | opnd1[7:0];
                cc_out[cc_v] = 1'b0;
            end
            op_eor: begin
                rslt[7:0]    = opnd0[7:0] ^ opnd1[7:0];
                cc_out[cc_v] = 1'b0;
            end
            op_clr: begin
                rslt[7:0]    = 8'd0;
                cc_out[cc_c] = 1'b0;
                cc_out[cc_v] = 1'b0;
            end
            op_com: begin
                rslt[7:0]    = ~opnd0[7:0];
                cc_out[cc_c] = 1'b1;
                cc_out[cc_v] = 1'b0;
            end
            op_neg: begin
                rslt[7:0]    = 8'd0 - opnd0[7:0];
                cc_out[cc_c] = opnd0[7:0] != 8'd0;
                cc_out[cc_v] = opnd0[7:0] == 8'h80;
            end
            op_inc: begin                        // C untouched
                rslt[7:0]    = opnd0[7:0] + 8'd1;
                cc_out[cc_v] = opnd0[7:0] == 8'h7f;
            end
            op_dec: begin
                rslt[7:0]    = opnd0[7:0] - 8'd1;
                cc_out[cc_v] = opnd0[7:0] == 8'h80;
            end
            op_lsr: {rslt[7:0], cc_out[cc_c]} = {1'b0, opnd0[7:0]};
            op_asr: {rslt[7:0], cc_out[cc_c]} = {opnd0[7], opnd0[7:0]};
            op_ror: {rslt[7:0], cc_out[cc_c]} = {cc_in[cc_c], opnd0[7:0]};
            op_asl, op_rol: begin
                {cc_out[cc_c], rslt[7:0]} = {opnd0[7:0], op == op_rol && cc_in[cc_c]};
                cc_out[cc_v] = opnd0[7] ^ opnd0[6];
            end
            op_lsrd: begin
                if (shd_busy) begin
                    {rslt, cc_out[cc_c]} = {1'b0, shd_data};
                end else begin
                    rslt = shd_data;             // C keeps the last bit out
                end
            end
            op_asld: begin
                if (shd_busy) begin
                    {cc_out[cc_c], rslt} = {shd_data, 1'b0};
                    cc_out[cc_v] = shd_data[15] ^ shd_data[14];
                end else begin
                    rslt = shd_data;
                end
            end
            op_andcc: cc_out = cc_in & opnd1[7:0];
            op_orcc:  cc_out = cc_in | opnd1[7:0];
            op_sex: begin
                rslt         = {{8{opnd0[7]}}, opnd0[7:0]};
                cc_out[cc_v] = 1'b0;
            end
            op_mul: begin                        // A times B into D
                rslt         = opnd0[15:8] * opnd0[7:0];
                cc_out[cc_c] = rslt[7];
            end
            op_lmul: begin
                prod         = opnd0 * opnd1;
                rslt         = prod[15:0];
                rslt_hi      = prod[31:16];
                cc_out[cc_c] = prod[31];
            end
            op_divxb: begin
                rslt         = div_quot;
                rslt_hi      = {8'd0, div_rem};
                cc_out[cc_v] = div_v;
            end
            default: rslt = opnd0;
        endcase
        if (op != op_andcc && op != op_orcc) begin
            cc_out[cc_z] = wide ? rslt == 16'd0 : rslt[7:0] == 8'd0;
            cc_out[cc_n] = wide ? rslt[15] : rslt[7];
        end
    end

    // Launch strobes only for a matching opcode and an idle unit
    assert property (@(posedge clk) disable iff (rst)
        div_en || shd_en |-> !(div_en && shd_en) && op_is_multi(op) && !busy)
        else $error("alu: bad divide or shift launch");

endmodule

// ==== kcpu_ccr.sv ====
//////////////////////////////////////////////////
// KCPU condition-code register
// Keeps the flags, captures the result words
// and pulses done after write-back
//////////////////////////////////////////////////
`timescale 1ns/1ps

module kcpu_ccr (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  logic        cc_we,
    input  logic        wb,
    input  logic [7:0]  cc_new,
    input  logic [15:0] rslt,
    input  logic [15:0] rslt_hi,
    output logic [7:0]  cc,
    output logic [15:0] result,
    output logic [15:0] result_hi,
    output logic        done
);
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cc   <= 8'd0;
            done <= 1'b0;
        end else if (cen) begin
            done <= wb;
            if (cc_we) begin
                cc <= cc_new;                    // Fed back as carry-in
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            result    <= 16'd0;
            result_hi <= 16'd0;
        end else if (cen && wb) begin
            result    <= rslt;
            result_hi <= rslt_hi;
        end
    end

    // Final flags must land together with the result
    assert property (@(posedge clk) disable iff (rst)
        wb |-> cc_we)
        else $error("ccr: write-back without a flag update");

endmodule

// ==== kcpu_exec.sv ====
//////////////////////////////////////////////////
// KCPU execute block top level
// Issue stage, operation unit and condition
// code register
//////////////////////////////////////////////////
`timescale 1ns/1ps

module kcpu_exec (
    input  logic               clk,
    input  logic               rst,
    input  logic               cen,
    input  logic               start,
    input  kcpu_pkg::kcpu_op_t op_in,
    input  logic [15:0]        a,
    input  logic [15:0]        b,
    output logic               ready,
    output logic               done,
    output logic [15:0]        result,
    output logic [15:0]        result_hi,
    output logic [7:0]         cc
);
    import kcpu_pkg::*;

    kcpu_op_t    op;
    logic [15:0] opnd0;
    logic [15:0] opnd1;
    logic [15:0] rslt;
    logic [15:0] rslt_hi;
    logic [7:0]  cc_alu;
    logic        busy;
    logic        div_en;
    logic        shd_en;
    logic        cc_we;
    logic        wb;

    kcpu_issue u_issue (
        .clk    (clk),
        .rst    (rst),
        .cen    (cen),
        .start  (start),
        .op_in  (op_in),
        .a      (a),
        .b      (b),
        .busy   (busy),
        .ready  (ready),
        .op     (op),
        .opnd0  (opnd0),
        .opnd1  (opnd1),
        .div_en (div_en),
        .shd_en (shd_en),
        .cc_we  (cc_we),
        .wb     (wb)
    );

    kcpu_alu u_alu (
        .clk     (clk),
        .rst     (rst),
        .cen     (cen),
        .op      (op),
        .opnd0   (opnd0),
        .opnd1   (opnd1),
        .cc_in   (cc),
        .div_en  (div_en),
        .shd_en  (shd_en),
        .cc_out  (cc_alu),
        .busy    (busy),
        .rslt    (rslt),
        .rslt_hi (rslt_hi)
    );

    kcpu_ccr u_ccr (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .cc_we     (cc_we),
        .wb        (wb),
        .cc_new    (cc_alu),
        .rslt      (rslt),
        .rslt_hi   (rslt_hi),
        .cc        (cc),
        .result    (result),
        .result_hi (result_hi),
        .done      (done)
    );

endmodule

// ==== kcpu_exec_tb.sv ====
//////////////////////////////////////////////////
// KCPU execute block testbench
// Table of operations checked against a flag
// model, with back-pressure and clock-enable rows
//////////////////////////////////////////////////
`timescale 1ns/1ps

module kcpu_exec_tb;
    import kcpu_pkg::*;

    localparam int max_rows = 64;

    logic        clk;
    logic        rst;
    logic        cen;
    logic        start;
    kcpu_op_t    op_in;
    logic [15:0] a;
    logic [15:0] b;
    logic        ready;
    logic        done;
    logic [15:0] result;
    logic [15:0] result_hi;
    logic [7:0]  cc;

    string       row_name  [max_rows];
    kcpu_op_t    row_op    [max_rows];
    logic [15:0] row_a     [max_rows];
    logic [15:0] row_b     [max_rows];
    logic [15:0] row_res   [max_rows];
    logic [15:0] row_hi    [max_rows];
    logic [7:0]  row_cc    [max_rows];
    int          row_lat   [max_rows];  // Zero skips the latency check
    bit          row_poke  [max_rows];
    bit          row_stall [max_rows];
    int          n_rows;
    bit          table_done;
    logic [7:0]  model_cc;              // Flags as the model expects them
    int          seed;

    kcpu_exec dut0 (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .start     (start),
        .op_in     (op_in),
        .a         (a),
        .b         (b),
        .ready     (ready),
        .done      (done),
        .result    (result),
        .result_hi (result_hi),
        .cc        (cc)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("Mismatch in %s: expected %0h, actual %0h", what, exp, act);
            $display("CHECKS FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // 6809 style result and flag rules applied to the model flags f
    task automatic predict(
        input  kcpu_op_t    op,
        input  logic [15:0] x,
        input  logic [15:0] y,
        inout  logic [7:0]  f,
        output logic [15:0] r,
        output logic [15:0] h
    );
        logic [7:0]  lo;
        logic [15:0] t;
        logic [31:0] p;
        logic        ci;
        logic        k;
        logic        w;
        int          s;
        int          n;
        ci = f[cc_c];
        k  = ci && (op == op_adc || op == op_sbc);
        lo = x[7:0];
        r  = x;
        h  = 16'd0;
        w  = 1'b0;
        n  = int'(y[7:0]);
        case (op)
            op_ld8, op_tst8: begin
                if (op == op_ld8)
                    lo = y[7:0];
                f[cc_v] = 1'b0;
            end
            op_ld16, op_tst16: begin
                if (op == op_ld16)
                    r = y;
                f[cc_v] = 1'b0;
                w       = 1'b1;
            end
            op_add8, op_adc: begin
                s       = int'(x[7:0]) + int'(y[7:0]) + int'(k);
                lo      = s[7:0];
                f[cc_c] = s > 255;
                f[cc_h] = int'(x[3:0]) + int'(y[3:0]) + int'(k) > 15;  // Carry out of bit 3
                f[cc_v] = x[7] == y[7] && lo[7] != x[7];
            end
            op_sub8, op_cmp8, op_sbc: begin
                s       = int'(x[7:0]) - int'(y[7:0]) - int'(k);
                lo      = s[7:0];
                f[cc_c] = s < 0;                                        // Borrow
                f[cc_v] = x[7] != y[7] && lo[7] != x[7];
            end
            op_add16, op_sub16: begin
                s       = op == op_add16 ? int'(x) + int'(y) : int'(x) - int'(y);
                r       = s[15:0];
                f[cc_c] = s > 65535 || s < 0;
                // Add overflows on like signs, subtract on unlike signs
                f[cc_v] = (op == op_add16) == (x[15] == y[15]) && r[15] != x[15];
                w       = 1'b1;
            end
            op_and, op_or, op_eor: begin
                lo = op == op_and ? x[7:0] & y[7:0] :
                     op == op_or  ? x[7:0] | y[7:0] : x[7:0] ^ y[7:0];
                f[cc_v] = 1'b0;
            end
            op_clr: begin
                lo      = 8'd0;
                f[cc_c] = 1'b0;
                f[cc_v] = 1'b0;
            end
            op_com: begin
                lo      = ~x[7:0];
                f[cc_c] = 1'b1;
                f[cc_v] = 1'b0;
            end
            op_neg: begin
                lo      = 8'd0 - x[7:0];
                f[cc_c] = x[7:0] != 8'd0;
                f[cc_v] = x[7:0] == 8'h80;
            end
            op_inc: begin
                lo      = x[7:0] + 8'd1;
                f[cc_v] = x[7:0] == 8'h7f;
            end
            op_dec: begin
                lo      = x[7:0] - 8'd1;
                f[cc_v] = x[7:0] == 8'h80;
            end
            op_lsr, op_asr, op_ror: begin
                f[cc_c] = x[0];
                lo      = {op == op_asr ? x[7] : op == op_ror && ci, x[7:1]};
            end
            op_asl, op_rol: begin
                f[cc_c] = x[7];
                f[cc_v] = x[7] ^ x[6];
                lo      = {x[6:0], op == op_rol && ci};
            end
            op_lsrd: begin
                r = x >> n;
                if (n > 0) begin
                    t       = x >> (n - 1);      // Value before the last step
                    f[cc_c] = t[0];
                end
                w = 1'b1;
            end
            op_asld: begin
                r = x << n;
                if (n > 0) begin
                    t       = x << (n - 1);
                    f[cc_c] = t[15];
                    f[cc_v] = t[15] ^ t[14];
                end
                w = 1'b1;
            end
            op_andcc: f = f & y[7:0];
            op_orcc:  f = f | y[7:0];
            op_sex: begin
                r       = {{8{x[7]}}, x[7:0]};
                f[cc_v] = 1'b0;
                w       = 1'b1;
            end
            op_mul: begin
                r       = 16'(x[15:8]) * 16'(x[7:0]);
                f[cc_c] = r[7];
                w       = 1'b1;
            end
            op_lmul: begin
                p       = 32'(x) * 32'(y);
                r       = p[15:0];
                h       = p[31:16];
                f[cc_c] = p[31];
                w       = 1'b1;
            end
            op_divxb: begin
                if (y[7:0] == 8'd0) begin
                    r = 16'hffff;                // Saturated quotient
                    h = {8'd0, x[7:0]};
                end else begin
                    r = x / 16'(y[7:0]);
                    h = x % 16'(y[7:0]);
                end
                f[cc_v] = y[7:0] == 8'd0;
                w       = 1'b1;
            end
            default: ;
        endcase
        if (!w)
            r = {x[15:8], lo};                   // High byte passes through
        if (op != op_andcc && op != op_orcc) begin
            f[cc_n] = w ? r[15] : r[7];
            f[cc_z] = w ? r == 16'd0 : r[7:0] == 8'd0;
        end
    endtask

    task automatic add_row(input string nm, input kcpu_op_t op, input logic [15:0] x,
                           input logic [15:0] y, input bit poke, input bit stall);
        logic [15:0] r;
        logic [15:0] h;
        predict(op, x, y, model_cc, r, h);
        row_name[n_rows]  = nm;
        row_op[n_rows]    = op;
        row_a[n_rows]     = x;
        row_b[n_rows]     = y;
        row_res[n_rows]   = r;
        row_hi[n_rows]    = h;
        row_cc[n_rows]    = model_cc;
        row_poke[n_rows]  = poke;
        row_stall[n_rows] = stall;
        if (op == op_lsrd || op == op_asld)
            row_lat[n_rows] = 3 + int'(y[7:0]);
        else if (op == op_divxb)
            row_lat[n_rows] = 0;                 // Divide ends on done only
        else
            row_lat[n_rows] = 3;
        n_rows++;
    endtask

    task automatic run_row(input int i);
        int cycles;
        int hold;
        bit stalled;
        bit seen;
        cycles  = 0;
        hold    = 0;
        stalled = 1'b0;
        seen    = 1'b0;
        @(posedge clk);
        while (!ready)
            @(posedge clk);
        start <= 1'b1;
        op_in <= row_op[i];
        a     <= row_a[i];
        b     <= row_b[i];
        @(posedge clk);                          // Request accepted here
        start <= row_poke[i];                    // Must be ignored while ready is low
        if (row_poke[i]) begin
            op_in <= op_clr;
            a     <= 16'hffff;
            b     <= 16'hffff;
        end
        while (!seen) begin
            @(posedge clk);
            if (cen)
                cycles++;
            if (done) begin
                seen = 1'b1;
            end else begin
                start <= 1'b0;
                if (row_stall[i] && cycles == 1 && !stalled) begin
                    cen     <= 1'b0;
                    hold    = 4;
                    stalled = 1'b1;
                end else if (hold > 0) begin
                    hold = hold - 1;
                    if (hold == 0)
                        cen <= 1'b1;
                end
            end
        end
        check({row_name[i], " result"}, 32'(row_res[i]), 32'(result));
        check({row_name[i], " result_hi"}, 32'(row_hi[i]), 32'(result_hi));
        check({row_name[i], " cc"}, 32'(row_cc[i]), 32'(cc));
        check({row_name[i], " ready at done"}, 32'(1'b1), 32'(ready));
        if (row_lat[i] != 0)
            check({row_name[i], " latency"}, row_lat[i], cycles);
    endtask

    task automatic build_table();
        logic [15:0] ra;
        logic [15:0] rb;
        add_row("ld8", op_ld8, 16'h1234, 16'h0080, 0, 0);
        add_row("ld16", op_ld16, 16'h0000, 16'h8000, 0, 0);
        add_row("tst8_zero", op_tst8, 16'h5500, 16'h0000, 0, 0);
        add_row("tst16", op_tst16, 16'h0100, 16'h0000, 0, 0);
        add_row("add8_carry", op_add8, 16'h00ff, 16'h0001, 0, 0);
        add_row("adc_carry_in", op_adc, 16'h0010, 16'h0020, 0, 0);
        add_row("add8_overflow", op_add8, 16'h007f, 16'h0001, 0, 0);
        add_row("add16_carry", op_add16, 16'hffff, 16'h0002, 0, 0);
        add_row("add16_overflow", op_add16, 16'h7fff, 16'h0001, 0, 0);
        add_row("sub8_borrow", op_sub8, 16'h0010, 16'h0020, 0, 0);
        add_row("sbc_borrow_in", op_sbc, 16'h0050, 16'h0010, 0, 0);
        add_row("sub16_overflow", op_sub16, 16'h8000, 16'h0001, 0, 0);
        add_row("cmp8_equal", op_cmp8, 16'h0042, 16'h0042, 0, 0);
        add_row("and", op_and, 16'habf0, 16'h003c, 0, 0);
        add_row("or", op_or, 16'h0012, 16'h0080, 0, 0);
        add_row("eor", op_eor, 16'h00ff, 16'h00ff, 0, 0);
        add_row("clr", op_clr, 16'h55aa, 16'h0000, 0, 0);
        add_row("com", op_com, 16'h0055, 16'h0000, 0, 0);
        add_row("neg", op_neg, 16'h0001, 16'h0000, 0, 0);
        add_row("neg_min", op_neg, 16'h0080, 16'h0000, 0, 0);
        add_row("inc_overflow", op_inc, 16'h007f, 16'h0000, 0, 0);
        add_row("dec_overflow", op_dec, 16'h0080, 16'h0000, 0, 0);
        add_row("sex", op_sex, 16'h0080, 16'h0000, 0, 0);
        add_row("orcc", op_orcc, 16'h1111, 16'h0051, 0, 0);
        add_row("andcc", op_andcc, 16'h2222, 16'h00fe, 0, 0);
        add_row("lsr", op_lsr, 16'h0081, 16'h0000, 0, 0);
        add_row("asr", op_asr, 16'h0081, 16'h0000, 0, 0);
        add_row("asl", op_asl, 16'h00c0, 16'h0000, 0, 0);
        add_row("rol", op_rol, 16'h0040, 16'h0000, 0, 0);
        add_row("ror", op_ror, 16'h0002, 16'h0000, 0, 0);
        add_row("lsrd_0", op_lsrd, 16'h8001, 16'h0000, 0, 0);
        add_row("lsrd_1", op_lsrd, 16'h8001, 16'h0001, 0, 0);
        add_row("lsrd_5", op_lsrd, 16'hf0f0, 16'h0005, 0, 0);
        add_row("asld_0", op_asld, 16'h4001, 16'h0000, 0, 0);
        add_row("asld_1", op_asld, 16'h4001, 16'h0001, 0, 0);
        add_row("asld_5", op_asld, 16'h0c21, 16'h0005, 0, 0);
        add_row("mul", op_mul, 16'h0c0a, 16'h0000, 0, 0);
        add_row("mul_max", op_mul, 16'hffff, 16'h0000, 0, 0);
        add_row("lmul", op_lmul, 16'h1234, 16'h5678, 0, 0);
        add_row("divxb", op_divxb, 16'h1234, 16'h0007, 0, 0);
        add_row("divxb_zero", op_divxb, 16'habcd, 16'h0000, 0, 0);
        add_row("start_ignored", op_sub16, 16'h1000, 16'h0234, 1, 0);
        add_row("cen_stall_shift", op_asld, 16'h00ff, 16'h0003, 0, 1);
        add_row("cen_stall_div", op_divxb, 16'hfedc, 16'h0031, 0, 1);
        for (int j = 0; j < 4; j++) begin
            ra = 16'($random(seed));
            rb = 16'($random(seed));
            add_row($sformatf("rnd_add8_%0d", j), op_add8, ra, rb, 0, 0);
            add_row($sformatf("rnd_sub8_%0d", j), op_sub8, rb, ra, 0, 0);
            add_row($sformatf("rnd_and_%0d", j), op_and, ra, rb, 0, 0);
        end
    endtask

    initial begin
        rst        = 1'b1;
        cen        = 1'b1;
        start      = 1'b0;
        op_in      = op_ld8;
        a          = 16'd0;
        b          = 16'd0;
        n_rows     = 0;
        table_done = 1'b0;
        model_cc   = 8'd0;                       // Flags clear after reset
        seed       = 83948;
        build_table();
        table_done = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check("reset ready", 32'(1'b1), 32'(ready));
        check("reset cc", 32'(8'd0), 32'(cc));
        check("reset result", 32'(16'd0), 32'(result));
        check("reset done", 32'(1'b0), 32'(done));
        for (int i = 0; i < n_rows; i++)
            run_row(i);
        $display("ALL CHECKS PASSED");
        $finish;
    end

    // Budget of 25 cycles per row plus one row for reset
    initial begin
        wait (table_done);
        repeat ((n_rows + 1) * 25) @(posedge clk);
        $display("Timeout: the test rows did not complete within %0d cycles",
                 (n_rows + 1) * 25);
        $display("CHECKS FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== list.f ====
kcpu_pkg.sv
kcpu_div.sv
kcpu_issue.sv
kcpu_alu.sv
kcpu_ccr.sv
kcpu_exec.sv
kcpu_exec_tb.sv

// ==== Makefile ====
# Verilator build for the KCPU execute block testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module kcpu_exec_tb -f list.f

run: compile
	@out="$$(./obj_dir/Vkcpu_exec_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^ALL CHECKS PASSED$$"

clean:
	rm -rf obj_dir
